// ==== source/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// ----------------------------------------------------------------------
// datapath widths.
// ----------------------------------------------------------------------

// integer register and data width.
`define RV_XLEN 64

// instruction word width.
`define RV_INST_W 32

// ----------------------------------------------------------------------
// link sizing.
// ----------------------------------------------------------------------

// input fifo entries, equal to the producer's starting credits.
`define RV_QUEUE_DEPTH 4

// consumer buffer size, equal to the starting output credits.
`define RV_OUT_CREDITS 2

`endif

// ==== source/rv_isa_pkg.sv ====
`include "rv_settings.svh"

package rv_isa_pkg;

  // ----------------------------------------------------------------------
  // major opcodes, bits [6:0] of the instruction.
  // ----------------------------------------------------------------------
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // alu operations.
  // blt and bltu reuse slt and sltu.
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_IMM,
    ALU_EQ,
    ALU_NE,
    ALU_GE,
    ALU_GEU
  } alu_op_e;

  // decoder output consumed by the execute stage.
  typedef struct packed {
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] imm;
    alu_op_e             alu_op;
    logic                need_imm;
    logic                reg_wen;
    logic                is_auipc;
    logic                is_jal;
    logic                is_jalr;
    logic                is_branch;
    logic                is_ebreak;
    logic                illegal;
  } decoded_t;

endpackage

// ==== source/rv_link_pkg.sv ====
`include "rv_settings.svh"

package rv_link_pkg;

  // ----------------------------------------------------------------------
  // producer to unit.
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_INST_W-1:0] inst;
  } inst_pkt_t;

  // ----------------------------------------------------------------------
  // unit to consumer, one per instruction.
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_INST_W-1:0] inst;
    logic [4:0]            rd;
    logic                  wen;
    logic [`RV_XLEN-1:0]   value;
    logic [`RV_XLEN-1:0]   next_pc;
    logic                  illegal;
    logic                  ebreak;
  } retire_pkt_t;

endpackage

// ==== source/inst_queue.sv ====
`include "rv_settings.svh"

module inst_queue (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  rv_link_pkg::inst_pkt_t in_pkt,
  input  logic                  pop,
  output logic                  head_valid,
  output rv_link_pkg::inst_pkt_t head_pkt,
  output logic                  in_credit
);

  localparam int PTR_W = $clog2(`RV_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`RV_QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`RV_QUEUE_DEPTH - 1);

  rv_link_pkg::inst_pkt_t mem [`RV_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign head_valid = (count != '0);
  assign head_pkt   = mem[rd_ptr];

  // storage. producer credits guarantee a free slot.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_pkt;
    end
  end

  // pointers and occupancy.
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(in_valid) - CNT_W'(pop);
    end
  end

  // one credit back per entry freed.
  always_ff @(posedge clk) begin
    if (reset) begin
      in_credit <= 1'b0;
    end else begin
      in_credit <= pop;
    end
  end

endmodule

// ==== source/decoder.sv ====
`include "rv_settings.svh"

module decoder (
  input  logic [`RV_INST_W-1:0] inst,
  output rv_isa_pkg::decoded_t  dec
);

  // ----------------------------------------------------------------------
  // instruction fields.
  // ----------------------------------------------------------------------
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] funct12;

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign funct12 = inst[31:20];

  logic op_imm;
  logic op_op;
  logic op_lui;
  logic op_auipc;
  logic op_jal;
  logic op_jalr;
  logic op_branch;
  logic op_system;

  assign op_imm    = (opcode == rv_isa_pkg::OP_IMM);
  assign op_op     = (opcode == rv_isa_pkg::OP);
  assign op_lui    = (opcode == rv_isa_pkg::LUI);
  assign op_auipc  = (opcode == rv_isa_pkg::AUIPC);
  assign op_jal    = (opcode == rv_isa_pkg::JAL);
  assign op_jalr   = (opcode == rv_isa_pkg::JALR);
  assign op_branch = (opcode == rv_isa_pkg::BRANCH);
  assign op_system = (opcode == rv_isa_pkg::SYSTEM);

  // ----------------------------------------------------------------------
  // instruction terms.
  // ----------------------------------------------------------------------
  logic f7_zero;
  logic f7_alt;
  logic sh_zero;
  logic sh_alt;

  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);
  // rv64 shift immediates carry a 6-bit shamt.
  assign sh_zero = (inst[31:26] == 6'b000000);
  assign sh_alt  = (inst[31:26] == 6'b010000);

  logic addi, slti, sltiu, andi, ori, xori, slli, srli, srai;
  logic add, sub, slt, sltu, and_r, or_r, xor_r, sll, srl, sra;
  logic beq, bne, blt, bge, bltu, bgeu;
  logic ebreak;
  logic legal;

  assign addi  = op_imm & (funct3 == 3'b000);
  assign slti  = op_imm & (funct3 == 3'b010);
  assign sltiu = op_imm & (funct3 == 3'b011);
  assign xori  = op_imm & (funct3 == 3'b100);
  assign ori   = op_imm & (funct3 == 3'b110);
  assign andi  = op_imm & (funct3 == 3'b111);
  assign slli  = op_imm & (funct3 == 3'b001) & sh_zero;
  assign srli  = op_imm & (funct3 == 3'b101) & sh_zero;
  assign srai  = op_imm & (funct3 == 3'b101) & sh_alt;

  assign add   = op_op & (funct3 == 3'b000) & f7_zero;
  assign sub   = op_op & (funct3 == 3'b000) & f7_alt;
  assign sll   = op_op & (funct3 == 3'b001) & f7_zero;
  assign slt   = op_op & (funct3 == 3'b010) & f7_zero;
  assign sltu  = op_op & (funct3 == 3'b011) & f7_zero;
  assign xor_r = op_op & (funct3 == 3'b100) & f7_zero;
  assign srl   = op_op & (funct3 == 3'b101) & f7_zero;
  assign sra   = op_op & (funct3 == 3'b101) & f7_alt;
  assign or_r  = op_op & (funct3 == 3'b110) & f7_zero;
  assign and_r = op_op & (funct3 == 3'b111) & f7_zero;

  assign beq   = op_branch & (funct3 == 3'b000);
  assign bne   = op_branch & (funct3 == 3'b001);
  assign blt   = op_branch & (funct3 == 3'b100);
  assign bge   = op_branch & (funct3 == 3'b101);
  assign bltu  = op_branch & (funct3 == 3'b110);
  assign bgeu  = op_branch & (funct3 == 3'b111);

  assign ebreak = op_system & (funct3 == 3'b000) & (funct12 == 12'b000000000001);

  // loads and stores are not in this list on purpose.
  assign legal = addi | slti | sltiu | andi | ori | xori | slli | srli | srai |
                 add | sub | slt | sltu | and_r | or_r | xor_r | sll | srl | sra |
                 op_lui | op_auipc | op_jal | op_jalr |
                 beq | bne | blt | bge | bltu | bgeu | ebreak;

  // ----------------------------------------------------------------------
  // immediate by format, r-type gets zero.
  // ----------------------------------------------------------------------
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_b;

  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};
  assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                  inst[11:8], 1'b0};

  always_comb begin
    dec = '0;
    dec.rd  = inst[11:7];
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];

    if (op_imm | op_jalr) begin
      dec.imm = imm_i;
    end else if (op_lui | op_auipc) begin
      dec.imm = imm_u;
    end else if (op_jal) begin
      dec.imm = imm_j;
    end else if (op_branch) begin
      dec.imm = imm_b;
    end

    // add covers auipc and the jumps too.
    if (sub)                       dec.alu_op = rv_isa_pkg::ALU_SUB;
    else if (slti | slt | blt)     dec.alu_op = rv_isa_pkg::ALU_SLT;
    else if (sltiu | sltu | bltu)  dec.alu_op = rv_isa_pkg::ALU_SLTU;
    else if (andi | and_r)         dec.alu_op = rv_isa_pkg::ALU_AND;
    else if (ori | or_r)           dec.alu_op = rv_isa_pkg::ALU_OR;
    else if (xori | xor_r)         dec.alu_op = rv_isa_pkg::ALU_XOR;
    else if (slli | sll)           dec.alu_op = rv_isa_pkg::ALU_SLL;
    else if (srli | srl)           dec.alu_op = rv_isa_pkg::ALU_SRL;
    else if (srai | sra)           dec.alu_op = rv_isa_pkg::ALU_SRA;
    else if (op_lui)               dec.alu_op = rv_isa_pkg::ALU_PASS_IMM;
    else if (beq)                  dec.alu_op = rv_isa_pkg::ALU_EQ;
    else if (bne)                  dec.alu_op = rv_isa_pkg::ALU_NE;
    else if (bge)                  dec.alu_op = rv_isa_pkg::ALU_GE;
    else if (bgeu)                 dec.alu_op = rv_isa_pkg::ALU_GEU;
    else                           dec.alu_op = rv_isa_pkg::ALU_ADD;

    dec.need_imm  = op_imm | op_lui | op_auipc | op_jal | op_jalr;
    dec.reg_wen   = (op_imm | op_lui | op_auipc | op_op | op_jal | op_jalr) & legal;
    dec.is_auipc  = op_auipc;
    dec.is_jal    = op_jal;
    dec.is_jalr   = op_jalr;
    dec.is_branch = op_branch & legal;
    dec.is_ebreak = ebreak;
    dec.illegal   = ~legal;
  end

endmodule

// ==== source/exec_unit.sv ====
`include "rv_settings.svh"

module exec_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     head_valid,
  input  rv_link_pkg::inst_pkt_t   head_pkt,
  input  rv_isa_pkg::decoded_t     dec,
  input  logic                     ret_ready,
  output logic                     pop,
  output logic                     ret_valid,
  output rv_link_pkg::retire_pkt_t ret_pkt
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] regs [32];
  logic [`RV_XLEN-1:0] rs1_val;
  logic [`RV_XLEN-1:0] rs2_val;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_res;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_target;
  logic [`RV_XLEN-1:0] wb_val;
  logic [`RV_XLEN-1:0] next_pc;
  logic                taken;

  assign pop = head_valid & ret_ready;

  // ----------------------------------------------------------------------
  // operands. x0 reads as zero.
  // ----------------------------------------------------------------------
  assign rs1_val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
  assign rs2_val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];
  assign op_a    = dec.is_auipc ? head_pkt.pc : rs1_val;
  assign op_b    = dec.need_imm ? dec.imm : rs2_val;

  always_comb begin
    case (dec.alu_op)
      rv_isa_pkg::ALU_ADD:      alu_res = op_a + op_b;
      rv_isa_pkg::ALU_SUB:      alu_res = op_a - op_b;
      rv_isa_pkg::ALU_SLT:      alu_res = `RV_XLEN'($signed(op_a) < $signed(op_b));
      rv_isa_pkg::ALU_SLTU:     alu_res = `RV_XLEN'(op_a < op_b);
      rv_isa_pkg::ALU_AND:      alu_res = op_a & op_b;
      rv_isa_pkg::ALU_OR:       alu_res = op_a | op_b;
      rv_isa_pkg::ALU_XOR:      alu_res = op_a ^ op_b;
      rv_isa_pkg::ALU_SLL:      alu_res = op_a << op_b[SHAMT_W-1:0];
      rv_isa_pkg::ALU_SRL:      alu_res = op_a >> op_b[SHAMT_W-1:0];
      rv_isa_pkg::ALU_SRA:      alu_res = $unsigned($signed(op_a) >>> op_b[SHAMT_W-1:0]);
      rv_isa_pkg::ALU_PASS_IMM: alu_res = op_b;
      rv_isa_pkg::ALU_EQ:       alu_res = `RV_XLEN'(op_a == op_b);
      rv_isa_pkg::ALU_NE:       alu_res = `RV_XLEN'(op_a != op_b);
      rv_isa_pkg::ALU_GE:       alu_res = `RV_XLEN'($signed(op_a) >= $signed(op_b));
      rv_isa_pkg::ALU_GEU:      alu_res = `RV_XLEN'(op_a >= op_b);
      default:                  alu_res = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // link value and next pc.
  // ----------------------------------------------------------------------
  assign pc_plus4  = head_pkt.pc + `RV_XLEN'(4);
  assign pc_target = head_pkt.pc + dec.imm;
  assign taken     = dec.is_branch & (alu_res != '0);
  assign wb_val    = (dec.is_jal | dec.is_jalr) ? pc_plus4 : alu_res;

  always_comb begin
    if (dec.is_jalr) begin
      next_pc = {alu_res[`RV_XLEN-1:1], 1'b0};
    end else if (dec.is_jal | taken) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // register file.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (pop && dec.reg_wen && (dec.rd != 5'd0)) begin
      regs[dec.rd] <= wb_val;
    end
  end

  // retire record.
  always_ff @(posedge clk) begin
    if (pop) begin
      ret_pkt.pc      <= head_pkt.pc;
      ret_pkt.inst    <= head_pkt.inst;
      ret_pkt.rd      <= dec.rd;
      ret_pkt.wen     <= dec.reg_wen;
      ret_pkt.value   <= wb_val;
      ret_pkt.next_pc <= next_pc;
      ret_pkt.illegal <= dec.illegal;
      ret_pkt.ebreak  <= dec.is_ebreak;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ret_valid <= 1'b0;
    end else begin
      ret_valid <= pop;
    end
  end

endmodule

// ==== source/retire_port.sv ====
`include "rv_settings.svh"

module retire_port (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     ret_valid,
  input  rv_link_pkg::retire_pkt_t ret_pkt,
  input  logic                     out_credit,
  output logic                     ret_ready,
  output logic                     out_valid,
  output rv_link_pkg::retire_pkt_t out_pkt
);

  localparam int CRED_W = $clog2(`RV_OUT_CREDITS + 1);

  rv_link_pkg::retire_pkt_t slots [2];
  logic              wr_ptr;
  logic              rd_ptr;
  logic [1:0]        count;
  logic [1:0]        count_next;
  logic [CRED_W-1:0] credits;
  logic              send;

  // ----------------------------------------------------------------------
  // send side.
  // ----------------------------------------------------------------------
  assign send      = (count != 2'd0) && (credits != '0);
  assign out_valid = send;
  assign out_pkt   = slots[rd_ptr];

  // a pop now lands here one edge after the record in flight.
  assign count_next = count + {1'b0, ret_valid} - {1'b0, send};
  assign ret_ready  = (count_next < 2'd2);

  always_ff @(posedge clk) begin
    if (ret_valid) begin
      slots[wr_ptr] <= ret_pkt;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
      count   <= 2'd0;
      credits <= CRED_W'(`RV_OUT_CREDITS);
    end else begin
      wr_ptr  <= wr_ptr ^ ret_valid;
      rd_ptr  <= rd_ptr ^ send;
      count   <= count_next;
      credits <= credits - CRED_W'(send) + CRED_W'(out_credit);
    end
  end

endmodule

// ==== source/rv_exec_top.sv ====
module rv_exec_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  rv_link_pkg::inst_pkt_t   in_pkt,
  output logic                     in_credit,
  output logic                     out_valid,
  output rv_link_pkg::retire_pkt_t out_pkt,
  input  logic                     out_credit
);

  logic                     head_valid;
  rv_link_pkg::inst_pkt_t   head_pkt;
  logic                     pop;
  rv_isa_pkg::decoded_t     dec;
  logic                     ret_ready;
  logic                     ret_valid;
  rv_link_pkg::retire_pkt_t ret_pkt;

  // ----------------------------------------------------------------------
  // queue, decode and execute, output port.
  // ----------------------------------------------------------------------
  inst_queue queue0 (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_pkt(in_pkt),
    .pop(pop), .head_valid(head_valid), .head_pkt(head_pkt), .in_credit(in_credit)
  );

  decoder decoder0 (.inst(head_pkt.inst), .dec(dec));

  exec_unit exec0 (
    .clk(clk), .reset(reset), .head_valid(head_valid), .head_pkt(head_pkt),
    .dec(dec), .ret_ready(ret_ready), .pop(pop), .ret_valid(ret_valid),
    .ret_pkt(ret_pkt)
  );

  retire_port port0 (
    .clk(clk), .reset(reset), .ret_valid(ret_valid), .ret_pkt(ret_pkt),
    .out_credit(out_credit), .ret_ready(ret_ready), .out_valid(out_valid),
    .out_pkt(out_pkt)
  );

endmodule

// ==== verification/tb_rv_exec.sv ====
`include "rv_settings.svh"

module tb_rv_exec;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic reset;
  logic in_valid;
  rv_link_pkg::inst_pkt_t in_pkt;
  logic in_credit;
  logic out_valid;
  rv_link_pkg::retire_pkt_t out_pkt;
  logic out_credit;

  logic [63:0] rf [32];
  rv_link_pkg::retire_pkt_t exp_q [$];
  rv_link_pkg::retire_pkt_t exp_rec;
  logic [63:0] pc;
  integer seed = 32'h9a5f2c8d;
  int errors = 0;
  int spent = 0;
  int returned = 0;
  int granted = 0;
  int owed = 0;
  int out_seen = 0;
  int quiet = 0;
  bit hold = 0;
  bit burst_done = 0;

  rv_exec_top dut0 (
    .clk(clk), .reset(reset), .in_valid(in_valid), .in_pkt(in_pkt),
    .in_credit(in_credit), .out_valid(out_valid), .out_pkt(out_pkt),
    .out_credit(out_credit)
  );

  always #10 clk = ~clk;

  // ----------------------------------------------------------------------
  // instruction encoders.
  // ----------------------------------------------------------------------
  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  // ----------------------------------------------------------------------
  // reference model for one instruction in program order.
  // ----------------------------------------------------------------------
  task automatic model_exec(input logic [31:0] inst, output rv_link_pkg::retire_pkt_t r);
    logic [63:0] a, b, v, ii, iu, ij, ib;
    logic [2:0] f3;
    logic [5:0] sh;
    logic legal, wen, tk, alt;
    f3 = inst[14:12];
    a = rf[inst[19:15]];
    b = rf[inst[24:20]];
    ii = {{52{inst[31]}}, inst[31:20]};
    iu = {{32{inst[31]}}, inst[31:12], 12'b0};
    ij = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    ib = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    legal = 1'b1;
    wen = 1'b1;
    tk = 1'b0;
    v = '0;
    r = '0;
    r.next_pc = pc + 64'd4;
    case (inst[6:0])
      7'h13, 7'h33: begin
        if (inst[6:0] == 7'h13) b = ii;
        sh = b[5:0];
        alt = (inst[6:0] == 7'h13) ? inst[30] : (inst[31:25] == 7'h20);
        if (inst[6:0] == 7'h33 && inst[31:25] != 7'h00 && !(alt && (f3 == 0 || f3 == 5)))
          legal = 1'b0;
        if (inst[6:0] == 7'h13 && (f3 == 1 || f3 == 5) &&
            inst[31:26] != 6'h00 && !(f3 == 5 && inst[31:26] == 6'h10))
          legal = 1'b0;
        case (f3)
          3'd0: v = (alt && inst[6:0] == 7'h33) ? a - b : a + b;
          3'd1: v = a << sh;
          3'd2: v = {63'b0, $signed(a) < $signed(b)};
          3'd3: v = {63'b0, a < b};
          3'd4: v = a ^ b;
          3'd5: begin
            if (alt) v = $signed(a) >>> sh;
            else v = a >> sh;
          end
          3'd6: v = a | b;
          default: v = a & b;
        endcase
      end
      7'h37: v = iu;
      7'h17: v = pc + iu;
      7'h6f: begin
        v = pc + 64'd4;
        r.next_pc = pc + ij;
      end
      7'h67: begin
        v = pc + 64'd4;
        r.next_pc = (a + ii) & ~64'd1;
      end
      7'h63: begin
        wen = 1'b0;
        case (f3)
          3'd0: tk = (a == b);
          3'd1: tk = (a != b);
          3'd4: tk = ($signed(a) < $signed(b));
          3'd5: tk = ($signed(a) >= $signed(b));
          3'd6: tk = (a < b);
          3'd7: tk = (a >= b);
          default: legal = 1'b0;
        endcase
        if (tk) r.next_pc = pc + ib;
      end
      7'h73: begin
        wen = 1'b0;
        r.ebreak = (f3 == 3'd0) && (inst[31:20] == 12'd1);
        legal = r.ebreak;
      end
      default: legal = 1'b0;
    endcase
    r.pc = pc;
    r.inst = inst;
    r.rd = inst[11:7];
    r.wen = wen & legal;
    r.value = v;
    r.illegal = ~legal;
    if (r.wen && r.rd != 5'd0) rf[r.rd] = v;
  endtask

  // ----------------------------------------------------------------------
  // producer side.
  // ----------------------------------------------------------------------
  task automatic fail_now(input string what);
    $display("%s at %0t", what, $time);
    $display("errors: %0d", errors + 1);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic issue(input logic [31:0] inst);
    rv_link_pkg::retire_pkt_t r;
    int t;
    model_exec(inst, r);
    exp_q.push_back(r);
    t = 0;
    while (`RV_QUEUE_DEPTH + returned - spent <= 0) begin
      @(posedge clk);
      in_valid <= 1'b0;
      t++;
      if (t > 300) fail_now("producer never got an input credit back");
    end
    @(posedge clk);
    in_valid <= 1'b1;
    in_pkt <= '{pc: pc, inst: inst};
    spent++;
    pc = pc + 64'd4;
  endtask

  task automatic idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      t++;
      if (t > 400) fail_now("retire records stopped arriving");
    end
  endtask

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      $display("ERROR %0t: pc %h %s got %h expected %h", $time, exp_rec.pc, name, got, exp);
      errors++;
    end
  endtask

  // consumer side checks every record and hands credits back.
  always @(posedge clk) begin
    if (out_valid) begin
      out_seen++;
      assert (out_seen <= `RV_OUT_CREDITS + granted) else begin
        $display("ERROR %0t: out_valid used more credits than granted", $time);
        errors++;
      end
      assert (exp_q.size() != 0) else begin
        $display("ERROR %0t: record arrived with nothing outstanding", $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp_rec = exp_q.pop_front();
        check_field("pc", out_pkt.pc, exp_rec.pc);
        check_field("inst", 64'(out_pkt.inst), 64'(exp_rec.inst));
        check_field("rd", 64'(out_pkt.rd), 64'(exp_rec.rd));
        check_field("wen", 64'(out_pkt.wen), 64'(exp_rec.wen));
        check_field("next_pc", out_pkt.next_pc, exp_rec.next_pc);
        check_field("illegal", 64'(out_pkt.illegal), 64'(exp_rec.illegal));
        check_field("ebreak", 64'(out_pkt.ebreak), 64'(exp_rec.ebreak));
        if (exp_rec.wen) check_field("value", out_pkt.value, exp_rec.value);
      end
      owed++;
    end
    if (!hold && owed > 0) begin
      out_credit <= 1'b1;
      owed--;
      granted++;
    end else begin
      out_credit <= 1'b0;
    end
    if (in_credit) begin
      returned++;
      quiet = 0;
    end else begin
      quiet++;
    end
  end

  // ----------------------------------------------------------------------
  // directed tests.
  // ----------------------------------------------------------------------
  task automatic test_alu_ops();
    logic [31:0] r;
    logic [11:0] imm;
    logic [6:0] f7;
    for (int i = 1; i < 8; i++) begin
      r = $random(seed);
      issue(enc_i(r[11:0], 5'd0, 3'd0, 5'(i), 7'h13));
    end
    for (int i = 0; i < 48; i++) begin
      r = $random(seed);
      imm = r[31:20];
      if (r[6:4] == 3'd1) imm = {6'h00, r[25:20]};
      if (r[6:4] == 3'd5) imm = {r[7] ? 6'h10 : 6'h00, r[25:20]};
      f7 = (r[7] && (r[6:4] == 3'd0 || r[6:4] == 3'd5)) ? 7'h20 : 7'h00;
      if (r[0])
        issue(enc_i(imm, {2'b0, r[10:8]}, r[6:4], {2'b0, r[13:11]}, 7'h13));
      else
        issue(enc_r(f7, {2'b0, r[16:14]}, {2'b0, r[10:8]}, r[6:4], {2'b0, r[13:11]}));
    end
    idle();
  endtask

  task automatic test_dependencies();
    issue(enc_i(12'd5, 5'd0, 3'd0, 5'd9, 7'h13));
    for (int i = 0; i < 6; i++) begin
      issue(enc_r(7'h00, 5'd9, 5'd9, 3'd0, 5'd9));
      issue(enc_i(12'hff3, 5'd9, 3'd4, 5'd10, 7'h13));
    end
    issue(enc_i(12'd123, 5'd9, 3'd0, 5'd0, 7'h13));
    issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd11));
    issue(enc_i(12'd7, 5'd0, 3'd6, 5'd12, 7'h13));
    idle();
  endtask

  task automatic test_control_flow();
    issue({20'hdead5, 5'd13, 7'h37});
    issue({20'h80001, 5'd14, 7'h17});
    issue(enc_j(21'h1ff000, 5'd1));
    issue(enc_i(12'd3, 5'd1, 3'd0, 5'd15, 7'h67));
    issue(enc_i(12'hffb, 5'd0, 3'd0, 5'd16, 7'h13));
    issue(enc_i(12'd3, 5'd0, 3'd0, 5'd17, 7'h13));
    for (int k = 0; k < 8; k++) begin
      if (k != 2 && k != 3) begin
        issue(enc_b(13'h0040, 5'd17, 5'd16, 3'(k)));
        issue(enc_b(13'h1ff0, 5'd16, 5'd17, 3'(k)));
        issue(enc_b(13'h0010, 5'd16, 5'd16, 3'(k)));
      end
    end
    idle();
  endtask

  task automatic test_illegal_ebreak();
    issue(enc_i(12'd8, 5'd2, 3'd3, 5'd18, 7'h03));
    issue({7'h00, 5'd3, 5'd2, 3'd3, 5'd8, 7'h23});
    issue(32'hffff_ffff);
    issue(enc_r(7'h01, 5'd3, 5'd2, 3'd0, 5'd19));
    issue(32'h0010_0073);
    issue(enc_r(7'h00, 5'd18, 5'd19, 3'd0, 5'd20));
    idle();
  endtask

  task automatic test_backpressure();
    int t;
    wait_drain();
    hold = 1'b1;
    burst_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 10; i++) issue(enc_i(12'(i), 5'd20, 3'd0, 5'd20, 7'h13));
        idle();
        burst_done = 1'b1;
      end
    join_none
    repeat (30) @(posedge clk);
    assert (quiet >= 10) else begin
      $display("ERROR %0t: in_credit still pulsing while output is blocked", $time);
      errors++;
    end
    assert (`RV_QUEUE_DEPTH + returned - spent == 0) else begin
      $display("ERROR %0t: producer credits not exhausted under back-pressure", $time);
      errors++;
    end
    hold = 1'b0;
    t = 0;
    while (!burst_done) begin
      @(posedge clk);
      t++;
      if (t > 400) fail_now("burst never finished after credits were released");
    end
    wait_drain();
  endtask

  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    in_pkt = '0;
    out_credit = 1'b0;
    pc = 64'h1000;
    for (int i = 0; i < 32; i++) rf[i] = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_alu_ops();
    test_dependencies();
    test_control_flow();
    test_illegal_ebreak();
    test_backpressure();
    wait_drain();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+source
source/rv_isa_pkg.sv
source/rv_link_pkg.sv
source/inst_queue.sv
source/decoder.sv
source/exec_unit.sv
source/retire_port.sv
source/rv_exec_top.sv
verification/tb_rv_exec.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f verilog.f --top-module tb_rv_exec -o sim_tb_rv_exec \
  && ./obj_dir/sim_tb_rv_exec > sim.log 2>&1 \
  || echo "build or run returned an error" >> sim.log
cat sim.log
grep -q ">>> PASS" sim.log && exit 0 || exit 1
